// File: list.f
hdl/sd_pkg.sv
hdl/sd_config_regs.sv
hdl/sd_integrator.sv
hdl/sd_window_counter.sv
hdl/sd_comb.sv
hdl/sd_channel.sv
hdl/sd_adc_top.sv
tests/sd_adc_asserts.sv
tests/sd_adc_tb.sv

// File: tests/sd_adc_tb.sv
// Testbench for sd_adc_top with a modulator bit every 8 system clocks
// Table ratios are multiples of 16 or use a constant bit, so each window holds
// a known number of ones wherever it starts
`default_nettype none

module sd_adc_tb;

    localparam int MAX_CREDITS = 4;

    typedef struct packed {
        logic [15:0] ratio;
        logic [4:0]  shift;
        logic [3:0]  channel;
        logic [4:0]  density;
        logic [1:0]  samples;
        logic [15:0] expected;
    } row_t;

    // Ratio, shift, channel, ones per 16 bits, samples to check and expected data,
    // which is (ones >> shift) - 2^15 and saturates at 16'h7fff
    localparam row_t ROWS [7] = '{
        {16'd256,   5'd0, 4'd3,  5'd8,  2'd2, 16'h8080},
        {16'd1024,  5'd2, 4'd5,  5'd12, 2'd2, 16'h80c0},
        {16'd4096,  5'd4, 4'd9,  5'd16, 2'd2, 16'h8100},
        {16'd512,   5'd1, 4'd0,  5'd0,  2'd2, 16'h8000},
        {16'd2048,  5'd0, 4'd15, 5'd16, 2'd2, 16'h8800},
        {16'd65535, 5'd0, 4'd1,  5'd16, 2'd1, 16'h7fff},
        {16'd0,     5'd0, 4'd2,  5'd16, 2'd1, 16'h7fff}
    };
    localparam row_t CREDIT_ROW  = {16'd256, 5'd0, 4'd7, 5'd8, 2'd0, 16'h8080};
    localparam row_t RESTART_ROW = {16'd256, 5'd0, 4'd7, 5'd4, 2'd1, 16'h8040};

    logic clock, rst_n, cfg_write, mod_clock, mod_data, sample_valid, credit_return;
    logic [15:0] cfg_wdata, cfg_rdata;
    sd_pkg::sd_reg_addr_e cfg_addr;
    sd_pkg::sd_sample_t sample;
    // Sink and modulator state
    logic sink_ready = 1'b0;
    int owed = 0;
    int density = 0;
    int phase = 0;
    int bit_index = 0;
    logic [31:0] rng_state = 32'h9b34;

    sd_adc_top #(.ACC_WIDTH(24), .MAX_CREDITS(MAX_CREDITS)) dut (
        .clock(clock), .rst_n(rst_n), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .mod_clock(mod_clock),
        .mod_data(mod_data), .sample_valid(sample_valid), .sample(sample),
        .credit_return(credit_return)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic int next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[31:20]);
    endfunction

    // One window of clocks plus synchronizer and pipeline latency
    function automatic int window_limit(input logic [15:0] ratio);
        return (ratio == 16'd0 ? 65536 : int'(ratio)) * 8 + 64;
    endfunction

    task automatic tick();
        @(posedge clock);
        #2;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_sample(input sd_pkg::sd_sample_t got, input sd_pkg::sd_sample_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED sample got %h expected %h", got, exp));
        end
    endtask

    task automatic check_reg(input sd_pkg::sd_reg_addr_e addr, input logic [15:0] exp);
        cfg_addr = addr;
        #1;
        if (cfg_rdata !== exp) begin
            report_failure($sformatf("FAILED cfg_rdata at %s got %h expected %h",
                addr.name(), cfg_rdata, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic write_reg(input sd_pkg::sd_reg_addr_e addr, input logic [15:0] data);
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_write = 1'b1;
        tick();
        cfg_write = 1'b0;
    endtask

    // Waits up to limit clocks for the next sample_valid and checks the word
    task automatic expect_sample(input int limit, input sd_pkg::sd_sample_t exp);
        int waited;
        waited = 0;
        tick();
        while (!sample_valid && waited < limit) begin
            tick();
            waited++;
        end
        if (!sample_valid) begin
            report_failure("Timed out waiting for sample_valid");
        end
        check_sample(sample, exp);
    endtask

    task automatic count_samples(input int cycles, output int seen);
        seen = 0;
        repeat (cycles) begin
            tick();
            if (sample_valid) begin
                seen++;
            end
        end
    endtask

    // Programs a row while disabled, waits a random gap, then enables and checks
    task automatic run_row(input row_t r);
        int k;
        write_reg(sd_pkg::REG_CONTROL, 16'h0000);
        write_reg(sd_pkg::REG_RATIO, r.ratio);
        write_reg(sd_pkg::REG_SHIFT, 16'(r.shift));
        write_reg(sd_pkg::REG_CHANNEL, 16'(r.channel));
        density = r.density;
        repeat (16 + next_random() % 16) begin
            tick();
        end
        write_reg(sd_pkg::REG_CONTROL, 16'h0001);
        for (k = 0; k < r.samples; k++) begin
            expect_sample(window_limit(r.ratio), {r.expected, r.channel});
        end
    endtask

    // Modulator clock is high in phases 0 to 3 and the bit moves one clock after its fall
    initial begin
        mod_clock = 1'b0;
        mod_data  = 1'b0;
        forever begin
            tick();
            phase     = (phase + 1) % 8;
            mod_clock = (phase < 4);
            if (phase == 5) begin
                mod_data  = ((bit_index % 16) < density);
                bit_index = bit_index + 1;
            end
        end
    end

    // Sink hands back one credit per clock for each sample it holds while ready
    initial begin
        credit_return = 1'b0;
        forever begin
            tick();
            if (sample_valid) begin
                owed++;
            end
            if (owed > MAX_CREDITS) begin
                report_failure("More samples outstanding than MAX_CREDITS");
            end
            if (dut.u_channel.u_asserts.failures != 0) begin
                report_failure("A bound assertion failed");
            end
            credit_return = sink_ready && owed > 0;
            if (credit_return) begin
                owed--;
            end
        end
    end

    initial begin
        int seen;
        int i;
        rst_n     = 1'b0;
        cfg_write = 1'b0;
        cfg_addr  = sd_pkg::REG_CONTROL;
        cfg_wdata = 16'h0000;
        repeat (3) begin
            tick();
        end
        rst_n = 1'b1;
        tick();
        // Reset values, then each field written with its spare bits set
        check_reg(sd_pkg::REG_CONTROL, 16'h0000);
        check_reg(sd_pkg::REG_RATIO, 16'h0100);
        check_reg(sd_pkg::REG_SHIFT, 16'h0000);
        check_reg(sd_pkg::REG_CHANNEL, 16'h0000);
        check_reg(sd_pkg::REG_STATUS, 16'h0000);
        write_reg(sd_pkg::REG_RATIO, 16'hbeef);
        check_reg(sd_pkg::REG_RATIO, 16'hbeef);
        write_reg(sd_pkg::REG_SHIFT, 16'hffff);
        check_reg(sd_pkg::REG_SHIFT, 16'h001f);
        write_reg(sd_pkg::REG_CHANNEL, 16'h00a5);
        check_reg(sd_pkg::REG_CHANNEL, 16'h0005);
        write_reg(sd_pkg::REG_CONTROL, 16'h0003);
        check_reg(sd_pkg::REG_CONTROL, 16'h0001);
        sink_ready = 1'b1;
        for (i = 0; i < $size(ROWS); i++) begin
            run_row(ROWS[i]);
        end
        // Without credits only MAX_CREDITS samples leave, then one is held and one dropped
        run_row(CREDIT_ROW);
        sink_ready = 1'b0;
        repeat (MAX_CREDITS) begin
            expect_sample(window_limit(16'd256), {16'h8080, 4'd7});
        end
        // The held window still carries tag 7, the dropped one gets tag 8
        count_samples(window_limit(16'd256), seen);
        check_count("sample_valid count without credits", seen, 0);
        write_reg(sd_pkg::REG_CHANNEL, 16'h0008);
        count_samples(window_limit(16'd256), seen);
        check_count("sample_valid count without credits", seen, 0);
        check_reg(sd_pkg::REG_STATUS, 16'h0001);
        sink_ready = 1'b1;
        expect_sample(32, {16'h8080, 4'd7});
        write_reg(sd_pkg::REG_STATUS, 16'h0000);
        check_reg(sd_pkg::REG_STATUS, 16'h0000);
        // Disable stops the flow and the first window after re-enable is exact
        expect_sample(window_limit(16'd256), {16'h8080, 4'd8});
        write_reg(sd_pkg::REG_CONTROL, 16'h0000);
        count_samples(2 * window_limit(16'd256), seen);
        check_count("sample_valid count while disabled", seen, 0);
        run_row(RESTART_ROW);
        if (dut.u_channel.u_asserts.failures == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_failure("A bound assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: tests/sd_adc_asserts.sv
// Concurrent checks on the credit counter and the output handshake of sd_channel
// Bound to every sd_channel instance and connected to its internal signals by name
`default_nettype none

module sd_adc_asserts #(
    parameter int MAX_CREDITS  = 4,
    parameter int CREDIT_WIDTH = 3
) (
    input wire logic                    clock,
    input wire logic                    rst_n,
    input wire logic [CREDIT_WIDTH-1:0] credits,
    input wire logic                    sample_valid,
    input wire logic                    pending_valid,
    input wire logic                    overrun_event
);

    // Count of failed assertions
    int failures = 0;

    // The counter starts full and may never climb above it
    credit_limit: assert property (@(posedge clock) disable iff (!rst_n)
        credits <= CREDIT_WIDTH'(MAX_CREDITS))
        else begin
            $error("credit counter above MAX_CREDITS");
            failures++;
        end

    // A sample on the bus was sent against a nonzero credit count
    valid_needs_credit: assert property (@(posedge clock) disable iff (!rst_n)
        sample_valid |-> credits != '0)
        else begin
            $error("sample_valid with zero credits");
            failures++;
        end

    // A drop only happens while the single slot is full
    overrun_when_pending: assert property (@(posedge clock) disable iff (!rst_n)
        overrun_event |-> pending_valid)
        else begin
            $error("overrun_event without a pending sample");
            failures++;
        end

endmodule

bind sd_channel sd_adc_asserts #(
    .MAX_CREDITS(MAX_CREDITS), .CREDIT_WIDTH(CREDIT_WIDTH)
) u_asserts (
    .clock(clock), .rst_n(rst_n), .credits(credits), .sample_valid(sample_valid),
    .pending_valid(pending_valid), .overrun_event(overrun_event)
);

`default_nettype wire

// File: hdl/sd_adc_top.sv
// Top level of the single-channel sigma-delta decimator
// The modulator clock is asynchronous to clock and is synchronized inside
// Output samples are paced by credit_return from the sink
`default_nettype none

module sd_adc_top #(
    parameter int ACC_WIDTH   = 24,
    parameter int MAX_CREDITS = 4
) (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 cfg_write,
    input  wire sd_pkg::sd_reg_addr_e cfg_addr,
    input  wire logic [15:0]          cfg_wdata,
    output logic [15:0]               cfg_rdata,
    input  wire logic                 mod_clock,
    input  wire logic                 mod_data,
    output logic                      sample_valid,
    output sd_pkg::sd_sample_t        sample,
    input  wire logic                 credit_return
);

    // Settings from the register block and the overrun pulse back to it
    sd_pkg::sd_cfg_t cfg;
    logic            overrun_event;

    sd_config_regs u_regs (
        .clock(clock), .rst_n(rst_n),
        .cfg_write(cfg_write), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .overrun_event(overrun_event), .cfg(cfg)
    );

    sd_channel #(.ACC_WIDTH(ACC_WIDTH), .MAX_CREDITS(MAX_CREDITS)) u_channel (
        .clock(clock), .rst_n(rst_n), .cfg(cfg),
        .mod_clock(mod_clock), .mod_data(mod_data),
        .sample_valid(sample_valid), .sample(sample),
        .credit_return(credit_return), .overrun_event(overrun_event)
    );

endmodule

`default_nettype wire

// File: hdl/sd_channel.sv
// One decimation channel with scaling, saturation and credit-based output
// ACC_WIDTH must exceed SAMPLE_WIDTH; the sink must not return more than it took
// One sample can wait for a credit; a further one is dropped and flagged
`default_nettype none

module sd_channel #(
    parameter int ACC_WIDTH   = 24,
    parameter int MAX_CREDITS = 4
) (
    input  wire logic              clock,
    input  wire logic              rst_n,
    input  wire sd_pkg::sd_cfg_t   cfg,
    input  wire logic              mod_clock,
    input  wire logic              mod_data,
    output logic                   sample_valid,
    output sd_pkg::sd_sample_t     sample,
    input  wire logic              credit_return,
    output logic                   overrun_event
);

    localparam int SW = sd_pkg::SAMPLE_WIDTH;
    localparam int CREDIT_WIDTH = $clog2(MAX_CREDITS + 1);
    localparam logic [SW-1:0] MID_SCALE = 1 << (SW - 1);
    localparam logic [SW-1:0] MAX_POS = MID_SCALE - 1'b1;

    logic                    mod_edge;
    logic [ACC_WIDTH-1:0]    acc_value;
    logic                    window_strobe;
    logic [ACC_WIDTH-1:0]    window_count;
    logic                    count_valid;
    logic [ACC_WIDTH-1:0]    shifted;
    logic [SW:0]             unsigned_val;
    logic [SW-1:0]           scaled_data;
    sd_pkg::sd_sample_t      staged;
    logic                    staged_valid;
    sd_pkg::sd_sample_t      pending_sample;
    logic                    pending_valid;
    logic [CREDIT_WIDTH-1:0] credits;
    logic [CREDIT_WIDTH:0]   credit_next;
    logic                    send;

    sd_integrator #(.ACC_WIDTH(ACC_WIDTH)) u_integrator (
        .clock(clock), .rst_n(rst_n), .enable(cfg.enable),
        .mod_clock(mod_clock), .mod_data(mod_data),
        .mod_edge(mod_edge), .acc_value(acc_value)
    );

    sd_window_counter u_window_counter (
        .clock(clock), .rst_n(rst_n), .enable(cfg.enable),
        .decim_ratio(cfg.decim_ratio), .mod_edge(mod_edge),
        .window_strobe(window_strobe)
    );

    sd_comb #(.ACC_WIDTH(ACC_WIDTH)) u_comb (
        .clock(clock), .rst_n(rst_n), .enable(cfg.enable),
        .window_strobe(window_strobe), .acc_value(acc_value),
        .window_count(window_count), .count_valid(count_valid)
    );

    // Any bit above the sample range folds into the overflow bit
    always_comb begin
        shifted      = window_count >> cfg.out_shift;
        unsigned_val = {|shifted[ACC_WIDTH-1:SW], shifted[SW-1:0]};
        if (unsigned_val[SW]) begin
            scaled_data = MAX_POS;
        end else begin
            scaled_data = unsigned_val[SW-1:0] - MID_SCALE;
        end
    end

    // Credits left after the sample now on the bus plus any credit coming back
    assign credit_next = {1'b0, credits} - sample_valid + credit_return;
    // The pending sample always goes ahead of a freshly staged one
    assign send = cfg.enable && (credit_next != '0) && (pending_valid || staged_valid);

    always_ff @(posedge clock) begin
        if (count_valid) begin
            staged.data       <= scaled_data;
            staged.channel_id <= cfg.channel_id;
        end
        if (send) begin
            sample <= pending_valid ? pending_sample : staged;
        end
        if (staged_valid && (pending_valid || !send)) begin
            if (!pending_valid || send) begin
                pending_sample <= staged;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            staged_valid  <= 1'b0;
            pending_valid <= 1'b0;
            sample_valid  <= 1'b0;
            overrun_event <= 1'b0;
            credits       <= CREDIT_WIDTH'(MAX_CREDITS);
        end else begin
            staged_valid  <= cfg.enable & count_valid;
            sample_valid  <= send;
            overrun_event <= cfg.enable & staged_valid & pending_valid & ~send;
            credits       <= credit_next[CREDIT_WIDTH-1:0];
            if (!cfg.enable) begin
                pending_valid <= 1'b0;
            end else if (staged_valid) begin
                // Staged sample waits, or replaces the one just sent
                pending_valid <= pending_valid | ~send;
            end else if (send) begin
                pending_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sd_comb.sv
// Comb stage that turns the running integrator value into a per-window count
// The stored value starts at zero on enable, matching the cleared integrator
// window_count is held between strobes and valid with count_valid
`default_nettype none

module sd_comb #(
    parameter int ACC_WIDTH = 24
) (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 enable,
    input  wire logic                 window_strobe,
    input  wire logic [ACC_WIDTH-1:0] acc_value,
    output logic [ACC_WIDTH-1:0]      window_count,
    output logic                      count_valid
);

    // Integrator value at the end of the previous window
    logic [ACC_WIDTH-1:0] prev_acc;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            prev_acc     <= '0;
            window_count <= '0;
            count_valid  <= 1'b0;
        end else if (!enable) begin
            prev_acc     <= '0;
            window_count <= '0;
            count_valid  <= 1'b0;
        end else begin
            count_valid <= window_strobe;
            if (window_strobe) begin
                // Wrapping difference is exact as long as a window fits in ACC_WIDTH
                window_count <= acc_value - prev_acc;
                prev_acc     <= acc_value;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sd_window_counter.sv
// Decimation window counter, strobing on the edge that completes R edges
// A ratio of 0 is taken as 65536 edges per window
// Ratio changes take effect at the next window boundary
`default_nettype none

module sd_window_counter (
    input  wire logic                           clock,
    input  wire logic                           rst_n,
    input  wire logic                           enable,
    input  wire logic [sd_pkg::RATIO_WIDTH-1:0] decim_ratio,
    input  wire logic                           mod_edge,
    output logic                                window_strobe
);

    logic [sd_pkg::RATIO_WIDTH-1:0] edge_count;
    logic [sd_pkg::RATIO_WIDTH-1:0] active_ratio;
    logic                           last_edge;

    // Ratio minus one wraps, which gives the full range for a ratio of 0
    assign last_edge     = (edge_count == active_ratio - 1'b1);
    assign window_strobe = mod_edge & last_edge;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            edge_count   <= '0;
            active_ratio <= '0;
        end else if (!enable) begin
            edge_count   <= '0;
            active_ratio <= decim_ratio;
        end else if (window_strobe) begin
            edge_count   <= '0;
            active_ratio <= decim_ratio;
        end else if (mod_edge) begin
            edge_count <= edge_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sd_integrator.sv
// Integrator stage: modulator clock and data pass through a two-flop synchronizer
// The modulator clock must be well below half the system clock rate
// mod_edge trails the modulator rising edge by 3 to 4 system clocks
`default_nettype none

module sd_integrator #(
    parameter int ACC_WIDTH = 24
) (
    input  wire logic        clock,
    input  wire logic        rst_n,
    input  wire logic        enable,
    input  wire logic        mod_clock,
    input  wire logic        mod_data,
    output logic             mod_edge,
    output logic [ACC_WIDTH-1:0] acc_value
);

    // Clock and data travel together so the bit is sampled with its own edge
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic       clock_prev;
    logic       rise;

    assign rise = clock_sync[1] & ~clock_prev;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            clock_sync <= '0;
            data_sync  <= '0;
            clock_prev <= 1'b0;
            mod_edge   <= 1'b0;
            acc_value  <= '0;
        end else begin
            clock_sync <= {clock_sync[0], mod_clock};
            data_sync  <= {data_sync[0], mod_data};
            clock_prev <= clock_sync[1];
            mod_edge   <= enable & rise;
            // The accumulator wraps; the comb stage undoes the wrap by subtraction
            if (!enable) begin
                acc_value <= '0;
            end else if (rise) begin
                acc_value <= acc_value + {{(ACC_WIDTH-1){1'b0}}, data_sync[1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sd_config_regs.sv
// Settings registers and sticky overrun status for one decimation channel
// Writes land on the next clock; readback is combinational
// Any write to REG_STATUS clears overrun, but a same-cycle overrun event wins
`default_nettype none

module sd_config_regs (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 cfg_write,
    input  wire sd_pkg::sd_reg_addr_e cfg_addr,
    input  wire logic [15:0]          cfg_wdata,
    output logic [15:0]               cfg_rdata,
    input  wire logic                 overrun_event,
    output sd_pkg::sd_cfg_t           cfg
);

    logic overrun;

    // Settings writes and the sticky status bit
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg             <= '0;
            cfg.decim_ratio <= sd_pkg::RATIO_WIDTH'(256);
            overrun         <= 1'b0;
        end else begin
            if (cfg_write) begin
                case (cfg_addr)
                    sd_pkg::REG_CONTROL: cfg.enable      <= cfg_wdata[0];
                    sd_pkg::REG_RATIO:   cfg.decim_ratio <= cfg_wdata[sd_pkg::RATIO_WIDTH-1:0];
                    sd_pkg::REG_SHIFT:   cfg.out_shift   <= cfg_wdata[sd_pkg::SHIFT_WIDTH-1:0];
                    sd_pkg::REG_CHANNEL: cfg.channel_id  <= cfg_wdata[sd_pkg::CHANNEL_WIDTH-1:0];
                    default: ;
                endcase
            end
            // A new overrun takes priority over a clear in the same cycle
            if (overrun_event) begin
                overrun <= 1'b1;
            end else if (cfg_write && cfg_addr == sd_pkg::REG_STATUS) begin
                overrun <= 1'b0;
            end
        end
    end

    // Readback, with each field zero-extended to the data width
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            sd_pkg::REG_CONTROL: cfg_rdata[0] = cfg.enable;
            sd_pkg::REG_RATIO:   cfg_rdata[sd_pkg::RATIO_WIDTH-1:0] = cfg.decim_ratio;
            sd_pkg::REG_SHIFT:   cfg_rdata[sd_pkg::SHIFT_WIDTH-1:0] = cfg.out_shift;
            sd_pkg::REG_CHANNEL: cfg_rdata[sd_pkg::CHANNEL_WIDTH-1:0] = cfg.channel_id;
            sd_pkg::REG_STATUS:  cfg_rdata[0] = overrun;
            default:             cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/sd_pkg.sv
// Shared widths, register map and word formats of the sigma-delta decimator
// SAMPLE_WIDTH is fixed here because sd_sample_t depends on it
// Register data is 16 bits wide; narrower fields are zero-extended on readback
`default_nettype none

package sd_pkg;

    // Field widths of the settings and of the output word
    localparam int RATIO_WIDTH   = 16;
    localparam int SHIFT_WIDTH   = 5;
    localparam int CHANNEL_WIDTH = 4;
    localparam int SAMPLE_WIDTH  = 16;

    // Register addresses seen on the configuration port
    typedef enum logic [2:0] {
        REG_CONTROL = 3'd0,
        REG_RATIO   = 3'd1,
        REG_SHIFT   = 3'd2,
        REG_CHANNEL = 3'd3,
        REG_STATUS  = 3'd4
    } sd_reg_addr_e;

    // Channel settings driven by the register block
    typedef struct packed {
        logic                     enable;
        logic [RATIO_WIDTH-1:0]   decim_ratio;
        logic [SHIFT_WIDTH-1:0]   out_shift;
        logic [CHANNEL_WIDTH-1:0] channel_id;
    } sd_cfg_t;

    // One decimated output sample, centred on zero and tagged with its channel
    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] data;
        logic [CHANNEL_WIDTH-1:0]       channel_id;
    } sd_sample_t;

endpackage

`default_nettype wire
